//--- common/dii_settings.svh
`ifndef DII_SETTINGS_SVH
`define DII_SETTINGS_SVH

// buffer depths in flits

// ring side only needs to absorb a short stall
`define DII_RING_BUF_SIZE 4

// a local packet must fit completely, full-packet mode
`define DII_LOCAL_BUF_SIZE 8

// destination field in the low bits of the first flit
`define DII_ADDR_W 8

`endif

//--- common/dii_pkg.sv
`default_nettype none

package dii_pkg;

   // one flit of a debug packet
   typedef struct packed {
      logic        valid;
      logic        last;          // marks the final flit
      logic [15:0] data;          // first flit carries the destination
   } dii_flit;

   // where the packet in flight through the demux is going
   typedef enum logic [1:0] {
      demux_idle,
      demux_to_local,
      demux_to_forward
   } demux_state;

   // which source currently owns the ring output
   typedef enum logic [1:0] {
      mux_idle,
      mux_from_forward,
      mux_from_local
   } mux_state;

   function automatic dii_flit dii_flit_assemble(
      input logic        valid,
      input logic        last,
      input logic [15:0] data
   );
      dii_flit f;
      f.valid = valid;
      f.last  = last;
      f.data  = data;
      return f;
   endfunction

endpackage

`default_nettype wire

//--- buffer/dii_buffer.sv
`default_nettype none

module dii_buffer #(
   parameter int BUF_SIZE   = 4,     // depth in flits
   parameter bit FULLPACKET = 0      // hold output until a whole packet is in
) (
   input  logic                        clk,
   input  logic                        rst,
   output logic [$clog2(BUF_SIZE)-1:0] packet_size,
   input  dii_pkg::dii_flit            flit_in,
   output logic                        flit_in_ready,
   output dii_pkg::dii_flit            flit_out,
   input  logic                        flit_out_ready
);
   import dii_pkg::*;

   localparam int ID_W  = $clog2(BUF_SIZE);
   localparam int PTR_W = ID_W + 1;

   dii_flit [BUF_SIZE-1:0] data;     // newest at index 0
   logic [PTR_W-1:0]       rp;       // oldest entry
   logic [ID_W-1:0]        rd_idx;
   logic                   not_empty;
   logic                   wr_en;
   logic                   rd_en;

   assign rd_idx        = rp[ID_W-1:0];
   assign flit_in_ready = !(not_empty && rp == PTR_W'(BUF_SIZE - 1));
   assign wr_en         = flit_in.valid && flit_in_ready;
   assign rd_en         = flit_out.valid && flit_out_ready;

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int i = BUF_SIZE - 1; i > 0; i--) begin
            data[i] <= data[i-1];
         end
         data[0] <= flit_in;
      end
   end

   // simultaneous read and write leaves rp in place
   always_ff @(posedge clk) begin
      if (rst) begin
         rp        <= '0;
         not_empty <= 1'b0;
      end else if (wr_en && !rd_en) begin
         if (not_empty) begin
            rp <= rp + 1'b1;
         end
         not_empty <= 1'b1;
      end else if (rd_en && !wr_en) begin
         if (rp == '0) begin
            not_empty <= 1'b0;
         end else begin
            rp <= rp - 1'b1;
         end
      end
   end

   generate
      if (FULLPACKET) begin : g_fullpacket
         logic [BUF_SIZE-1:0] last_buf;     // last flags, shifted with data
         logic [BUF_SIZE-1:0] occupied;
         logic [BUF_SIZE-1:0] last_live;    // last flags of stored flits only
         logic [PTR_W-1:0]    oldest_size;

         always_ff @(posedge clk) begin
            if (wr_en) begin
               last_buf <= {last_buf[BUF_SIZE-2:0], flit_in.last};
            end
         end

         always_comb begin
            for (int i = 0; i < BUF_SIZE; i++) begin
               occupied[i] = not_empty && (rp >= PTR_W'(i));
            end
         end

         assign last_live = last_buf & occupied;

         // higher index is older, so the last hit wins
         always_comb begin
            oldest_size = '0;
            for (int i = 0; i < BUF_SIZE; i++) begin
               if (last_live[i]) begin
                  oldest_size = rp - PTR_W'(i) + 1'b1;
               end
            end
         end

         assign packet_size = oldest_size[ID_W-1:0];
         assign flit_out    = dii_flit_assemble(|last_live, data[rd_idx].last,
                                                data[rd_idx].data);
      end else begin : g_normal
         assign packet_size = '0;
         assign flit_out    = dii_flit_assemble(not_empty, data[rd_idx].last,
                                                data[rd_idx].data);
      end
   endgenerate

   a_rp_range: assert property (@(posedge clk) disable iff (rst)
      rp <= PTR_W'(BUF_SIZE - 1))
      else $error("dii_buffer read pointer out of range");

   // a refused flit stays offered until it is taken
   a_full_holds: assert property (@(posedge clk) disable iff (rst)
      flit_in.valid && !flit_in_ready |=> flit_in.valid && $stable(flit_in))
      else $error("dii_buffer input flit dropped while not ready");

endmodule

`default_nettype wire

//--- logic/dii_demux.sv
`default_nettype none

`include "dii_settings.svh"

module dii_demux #(
   parameter int ADDR_W = `DII_ADDR_W
) (
   input  logic              clk,
   input  logic              rst,
   input  logic [ADDR_W-1:0] node_id,
   input  dii_pkg::dii_flit  flit_in,
   output logic              flit_in_ready,
   output dii_pkg::dii_flit  local_out,
   input  logic              local_out_ready,
   output dii_pkg::dii_flit  forward_out,
   input  logic              forward_out_ready
);
   import dii_pkg::*;

   demux_state state;
   logic       addr_match;       // only meaningful on a first flit
   logic       sel_local;
   logic       xfer;

   assign addr_match = flit_in.data[ADDR_W-1:0] == node_id;

   always_comb begin
      case (state)
         demux_to_local:   sel_local = 1'b1;
         demux_to_forward: sel_local = 1'b0;
         default:          sel_local = addr_match;   // head flit decides
      endcase
   end

   always_comb begin
      local_out         = flit_in;
      local_out.valid   = flit_in.valid && sel_local;
      forward_out       = flit_in;
      forward_out.valid = flit_in.valid && !sel_local;
   end

   assign flit_in_ready = sel_local ? local_out_ready : forward_out_ready;
   assign xfer          = flit_in.valid && flit_in_ready;

   // route is held from the head flit until the tail goes through
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= demux_idle;
      end else if (xfer) begin
         if (flit_in.last) begin
            state <= demux_idle;
         end else if (sel_local) begin
            state <= demux_to_local;
         end else begin
            state <= demux_to_forward;
         end
      end
   end

   a_one_output: assert property (@(posedge clk) disable iff (rst)
      !(local_out.valid && forward_out.valid))
      else $error("dii_demux drove both outputs");

endmodule

`default_nettype wire

//--- logic/dii_mux.sv
`default_nettype none

module dii_mux (
   input  logic             clk,
   input  logic             rst,
   input  dii_pkg::dii_flit forward_in,
   output logic             forward_in_ready,
   input  dii_pkg::dii_flit local_in,
   output logic             local_in_ready,
   output dii_pkg::dii_flit flit_out,
   input  logic             flit_out_ready
);
   import dii_pkg::*;

   mux_state state;
   logic     last_local;        // local won the previous packet
   logic     grant_local;

   always_comb begin
      case (state)
         mux_from_local:   grant_local = 1'b1;
         mux_from_forward: grant_local = 1'b0;
         default: begin
            if (local_in.valid && forward_in.valid) begin
               grant_local = !last_local;   // alternate on contention
            end else begin
               grant_local = local_in.valid;
            end
         end
      endcase
   end

   always_comb begin
      if (grant_local) begin
         flit_out = dii_flit_assemble(local_in.valid, local_in.last, local_in.data);
      end else begin
         flit_out = dii_flit_assemble(forward_in.valid, forward_in.last,
                                      forward_in.data);
      end
   end

   assign local_in_ready   = grant_local && flit_out_ready;
   assign forward_in_ready = !grant_local && flit_out_ready;

   // An offered head flit already locks the owner, so the output stays
   // stable even if the other source turns valid while we wait for ready.
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= mux_idle;
         last_local <= 1'b0;
      end else if (flit_out.valid) begin
         if (flit_out_ready && flit_out.last) begin
            state      <= mux_idle;
            last_local <= grant_local;          // round-robin update at tail
         end else if (grant_local) begin
            state <= mux_from_local;
         end else begin
            state <= mux_from_forward;
         end
      end
   end

   a_owner_held: assert property (@(posedge clk) disable iff (rst)
      state != mux_idle |=> state == $past(state) || state == mux_idle)
      else $error("dii_mux changed owner inside a packet");

   // needs both the owner lock here and stable upstream senders
   a_out_stable: assert property (@(posedge clk) disable iff (rst)
      flit_out.valid && !flit_out_ready |=> $stable(flit_out))
      else $error("dii_mux output changed before it was accepted");

endmodule

`default_nettype wire

//--- logic/dii_ring_node.sv
`default_nettype none

`include "dii_settings.svh"

module dii_ring_node (
   input  logic                                    clk,
   input  logic                                    rst,
   input  logic [`DII_ADDR_W-1:0]                  node_id,
   input  dii_pkg::dii_flit                        ring_in,
   output logic                                    ring_in_ready,
   output dii_pkg::dii_flit                        ring_out,
   input  logic                                    ring_out_ready,
   input  dii_pkg::dii_flit                        local_in,
   output logic                                    local_in_ready,
   output dii_pkg::dii_flit                        local_out,
   input  logic                                    local_out_ready,
   output logic [$clog2(`DII_LOCAL_BUF_SIZE)-1:0] local_packet_size
);
   import dii_pkg::*;

   dii_flit ring_buf_out;       // ring buffer to demux
   logic    ring_buf_out_ready;
   dii_flit forward;            // demux to mux
   logic    forward_ready;
   dii_flit local_buf_out;      // complete local packets to mux
   logic    local_buf_out_ready;

   dii_buffer #(
      .BUF_SIZE   (`DII_RING_BUF_SIZE),
      .FULLPACKET (0)
   ) i_ring_buf (
      .clk            (clk),
      .rst            (rst),
      .packet_size    (),
      .flit_in        (ring_in),
      .flit_in_ready  (ring_in_ready),
      .flit_out       (ring_buf_out),
      .flit_out_ready (ring_buf_out_ready)
   );

   dii_demux #(
      .ADDR_W (`DII_ADDR_W)
   ) i_demux (
      .clk               (clk),
      .rst               (rst),
      .node_id           (node_id),
      .flit_in           (ring_buf_out),
      .flit_in_ready     (ring_buf_out_ready),
      .local_out         (local_out),
      .local_out_ready   (local_out_ready),
      .forward_out       (forward),
      .forward_out_ready (forward_ready)
   );

   // whole packets only, so a slow local source cannot stall the ring
   dii_buffer #(
      .BUF_SIZE   (`DII_LOCAL_BUF_SIZE),
      .FULLPACKET (1)
   ) i_local_buf (
      .clk            (clk),
      .rst            (rst),
      .packet_size    (local_packet_size),
      .flit_in        (local_in),
      .flit_in_ready  (local_in_ready),
      .flit_out       (local_buf_out),
      .flit_out_ready (local_buf_out_ready)
   );

   dii_mux i_mux (
      .clk              (clk),
      .rst              (rst),
      .forward_in       (forward),
      .forward_in_ready (forward_ready),
      .local_in         (local_buf_out),
      .local_in_ready   (local_buf_out_ready),
      .flit_out         (ring_out),
      .flit_out_ready   (ring_out_ready)
   );

endmodule

`default_nettype wire

//--- verif/dii_ref_model.svh
`ifndef DII_REF_MODEL_SVH
`define DII_REF_MODEL_SVH

// expected flits per output, bit 15 of data tags the source
dii_flit exp_local[$];            // ring packets for this node
dii_flit exp_fwd[$];              // ring packets passing through
dii_flit exp_inj[$];              // packets from the local port

logic [31:0] rng_state = 32'd79983;
int          errors    = 0;
int          checks    = 0;
string       test_name = "none";

function automatic logic [31:0] next_rand();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

// a packet goes local when its head address matches the node
function automatic bit route_is_local(input logic [15:0] head,
                                      input logic [`DII_ADDR_W-1:0] id);
   return head[`DII_ADDR_W-1:0] == id;
endfunction

task automatic check_flit(input string what, input dii_flit exp, input dii_flit act);
   checks++;
   if (exp !== act) begin
      errors++;
      $display("error %s %s: expected valid=%b last=%b data=%h, actual valid=%b last=%b data=%h",
               test_name, what, exp.valid, exp.last, exp.data,
               act.valid, act.last, act.data);
   end
endtask

task automatic check_size(input string what,
                          input logic [$clog2(`DII_LOCAL_BUF_SIZE)-1:0] exp,
                          input logic [$clog2(`DII_LOCAL_BUF_SIZE)-1:0] act);
   checks++;
   if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %0d, actual %0d", test_name, what, exp, act);
   end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
   checks++;
   if (exp !== act) begin
      errors++;
      $display("error %s %s: expected %b, actual %b", test_name, what, exp, act);
   end
endtask

`endif

//--- verif/tb_dii_ring_node.sv
`default_nettype none

`include "dii_settings.svh"

module tb_dii_ring_node;
   timeunit 1ns;
   timeprecision 100ps;
   import dii_pkg::*;

   `include "dii_ref_model.svh"

   localparam logic [7:0] NODE_ID         = 8'h5a;
   localparam int         PLANNED_FLITS   = 50 * 8;
   localparam int         WATCHDOG_CYCLES = PLANNED_FLITS * 20 + 1000;

   logic    clk;
   logic    rst;
   logic [`DII_ADDR_W-1:0] node_id;
   dii_flit ring_in, ring_out, local_in, local_out;
   logic    ring_in_ready, ring_out_ready, local_in_ready, local_out_ready;
   logic [$clog2(`DII_LOCAL_BUF_SIZE)-1:0] local_packet_size;
   int      ring_mode, local_mode;      // 0 low, 1 high, 2 random
   int      tests = 0;
   int      test_errors;
   bit      ring_in_pkt;
   bit      ring_src;

   dii_ring_node i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      #(WATCHDOG_CYCLES * 8);
      $display("watchdog expired, the DUT stopped moving flits");
      $display("Test failed");
      $finish;
   end

   // output ready patterns
   always @(posedge clk) begin
      #1;
      ring_out_ready  = ring_mode == 2 ? next_rand() % 3 != 0 : ring_mode == 1;
      local_out_ready = local_mode == 2 ? next_rand() % 3 != 0 : local_mode == 1;
   end

   // compare process, transfers sampled mid-cycle
   always @(negedge clk) begin
      if (!rst && local_out.valid && local_out_ready) begin
         if (exp_local.size() == 0) begin
            errors++;
            $display("%s: unexpected flit %h on local_out", test_name, local_out.data);
         end else begin
            check_flit("local_out", exp_local.pop_front(), local_out);
         end
      end
      if (!rst && ring_out.valid && ring_out_ready) begin
         if (ring_in_pkt && ring_out.data[15] != ring_src) begin
            errors++;
            $display("%s: packets interleaved on ring_out", test_name);
         end
         ring_src    = ring_out.data[15];
         ring_in_pkt = !ring_out.last;
         if (ring_src ? exp_inj.size() == 0 : exp_fwd.size() == 0) begin
            errors++;
            $display("%s: unexpected flit %h on ring_out", test_name, ring_out.data);
         end else begin
            check_flit("ring_out", ring_src ? exp_inj.pop_front() : exp_fwd.pop_front(),
                       ring_out);
         end
      end
   end

   task automatic drive_ring_packet(input int len, input logic [7:0] addr);
      dii_flit f;
      bit      to_local;
      bit      ok;
      for (int i = 0; i < len; i++) begin
         f.valid = 1'b1;
         f.last  = i == len - 1;
         f.data  = i == 0 ? {1'b0, 7'(next_rand()), addr} : {1'b0, 15'(next_rand())};
         if (i == 0) to_local = route_is_local(f.data, node_id);
         if (to_local) exp_local.push_back(f);
         else exp_fwd.push_back(f);
         ring_in = f;
         do begin
            @(negedge clk);
            ok = ring_in_ready;
            @(posedge clk);
            #1;
         end while (!ok);
      end
      ring_in = '0;
   endtask

   task automatic drive_local_packet(input int len);
      dii_flit f;
      bit      ok;
      for (int i = 0; i < len; i++) begin
         f.valid = 1'b1;
         f.last  = i == len - 1;
         f.data  = {1'b1, 15'(next_rand())};   // source tag set
         exp_inj.push_back(f);
         local_in = f;
         do begin
            @(negedge clk);
            ok = local_in_ready;
            @(posedge clk);
            #1;
         end while (!ok);
      end
      local_in = '0;
   endtask

   function automatic logic [7:0] other_addr();
      logic [7:0] a;
      a = 8'(next_rand());
      return a == NODE_ID ? a ^ 8'h01 : a;
   endfunction

   task automatic wait_drain(input int max_cycles);
      int n;
      n = 0;
      while ((exp_local.size() + exp_fwd.size() + exp_inj.size()) != 0 && n < max_cycles) begin
         @(negedge clk);
         n++;
      end
      if (n >= max_cycles) begin
         errors++;
         $display("%s: expected flits never arrived", test_name);
      end
      @(posedge clk);
      #1;
   endtask

   task automatic start_test(input string name);
      test_name   = name;
      test_errors = errors;
   endtask

   task automatic end_test();
      tests++;
      $display("test %s finished with %0d errors", test_name, errors - test_errors);
   endtask

   initial begin
      rst = 1'b1;
      node_id = NODE_ID;
      ring_in = '0;
      local_in = '0;
      ring_out_ready = 1'b0;
      local_out_ready = 1'b0;
      ring_mode = 1;
      local_mode = 1;
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;

      start_test("reset");
      @(negedge clk);
      check_bit("ring_out.valid", 1'b0, ring_out.valid);
      check_bit("local_out.valid", 1'b0, local_out.valid);
      check_bit("ring_in_ready", 1'b1, ring_in_ready);
      check_bit("local_in_ready", 1'b1, local_in_ready);
      check_size("local_packet_size", '0, local_packet_size);
      @(posedge clk);
      #1;
      end_test();

      start_test("local_delivery");
      repeat (8) drive_ring_packet(1 + next_rand() % 8, NODE_ID);
      wait_drain(500);
      end_test();

      start_test("forwarding");
      repeat (8) drive_ring_packet(1 + next_rand() % 8, other_addr());
      wait_drain(500);
      end_test();

      start_test("local_injection");
      for (int p = 0; p < 4; p++) begin
         int len;
         len = 1 + next_rand() % 7;        // 8 would wrap the size field
         ring_mode = 0;
         drive_local_packet(len);
         @(negedge clk);
         check_size("local_packet_size", 3'(len), local_packet_size);
         @(posedge clk);
         #1 ring_mode = 1;
         wait_drain(200);
      end
      end_test();

      start_test("merge");
      ring_mode = 2;
      local_mode = 2;
      fork
         repeat (12) drive_ring_packet(1 + next_rand() % 8,
                                       next_rand() % 4 == 0 ? NODE_ID : other_addr());
         repeat (12) drive_local_packet(1 + next_rand() % 8);
      join
      wait_drain(2000);
      end_test();

      start_test("back_pressure");
      ring_mode = 1;
      local_mode = 0;
      fork
         repeat (3) drive_ring_packet(3 + next_rand() % 6, NODE_ID);
         begin
            int taken;                     // flits the ring buffer took so far
            taken = 0;
            do begin
               @(negedge clk);
               check_bit("ring_in_ready", taken < `DII_RING_BUF_SIZE, ring_in_ready);
               if (ring_in.valid && ring_in_ready) begin
                  taken++;
               end
            end while (ring_in_ready && taken <= `DII_RING_BUF_SIZE);
            repeat (10) @(negedge clk);
            @(posedge clk);
            #1 local_mode = 2;
         end
      join
      wait_drain(1000);
      end_test();

      $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
+incdir+common
+incdir+verif
common/dii_pkg.sv
buffer/dii_buffer.sv
logic/dii_demux.sv
logic/dii_mux.sv
logic/dii_ring_node.sv
verif/tb_dii_ring_node.sv

//--- Makefile
# Verilator build and run for the debug ring node

VERILATOR ?= verilator
TOP       ?= tb_dii_ring_node
RTL_TOP   ?= dii_ring_node
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Test passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
